// ==== common/zynq_shell_consts.svh ====
`ifndef ZYNQ_SHELL_CONSTS_SVH
`define ZYNQ_SHELL_CONSTS_SVH

// address width of host, core and DRAM requests
`define ZS_ADDR_W 32
// APB data width and width of every register word
`define ZS_DATA_W 32
// APB byte address width
`define ZS_APB_ADDR_W 8

// register map, byte offsets on the APB bus
`define ZS_REG_RUN 8'h00
`define ZS_REG_ALLOC 8'h04
`define ZS_REG_BASE 8'h08
`define ZS_REG_CORE 8'h0C
// first of four profiler words, 0x10 to 0x1C
`define ZS_REG_PROF 8'h10
`define ZS_REG_IO_POP 8'h20
`define ZS_REG_IO_CNT 8'h24

// width of the offset inside one 256 MB host window
`define ZS_HOST_OFF_W 28
// core DRAM starts here, removed by xor before the host base is added
`define ZS_DRAM_FLIP 32'h8000_0000

// profiler map, one bit per 8 MB region, indexed by address bits 29:23
`define ZS_PROF_BITS 128
`define ZS_PROF_LSB 23
`define ZS_PROF_IDX_W 7

// core i/o write capture
`define ZS_IO_DEPTH 8
`define ZS_IO_ADDR_W 23
`define ZS_IO_DATA_W 8

`endif

// ==== common/zynq_shell_pkg.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

package zynq_shell_pkg;

   // host window address as seen on the host port
   // bit 29 picks the window, bits 31:30 and 28 are not decoded
   typedef union packed {
      logic [`ZS_ADDR_W-1:0] raw;
      struct packed {
         logic [1:0]                rsvd_hi;
         logic                      win;
         logic                      rsvd_lo;
         logic [`ZS_HOST_OFF_W-1:0] offset;
      } fld;
   } host_addr_u;

   // one captured core i/o write, packed the way the host pops it
   typedef union packed {
      logic [`ZS_DATA_W-1:0] raw;
      struct packed {
         logic                     valid;
         logic [`ZS_IO_ADDR_W-1:0] addr;
         logic [`ZS_IO_DATA_W-1:0] data;
      } fld;
   } io_word_u;

endpackage

`default_nettype wire

// ==== common/mem_req_if.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

// address-only memory request with a write flag
// a request is taken in a cycle where valid and ready are both high
interface mem_req_if;

   logic                  valid;
   logic                  ready;
   logic                  we;
   logic [`ZS_ADDR_W-1:0] addr;

   // the side that issues requests
   modport source (output valid, output we, output addr, input ready);

   // the side that takes requests and drives ready
   modport sink (input valid, input we, input addr, output ready);

   // passive observer of accepted requests
   modport monitor (input valid, input ready, input addr);

endinterface

`default_nettype wire

// ==== csr/csr_apb.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module csr_apb
(
   input  wire                          aclk_i,
   input  wire                          arst_n_i,
   input  wire [`ZS_APB_ADDR_W-1:0]     paddr_i,
   input  wire                          psel_i,
   input  wire                          penable_i,
   input  wire                          pwrite_i,
   input  wire [`ZS_DATA_W-1:0]         pwdata_i,
   output logic [`ZS_DATA_W-1:0]        prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   input  wire [`ZS_PROF_BITS-1:0]      prof_map_i,
   input  zynq_shell_pkg::io_word_u     fifo_word_i,
   input  wire                          fifo_empty_i,
   input  wire [$clog2(`ZS_IO_DEPTH+1)-1:0] fifo_count_i,
   output logic                         fifo_pop_o,
   output logic                         shell_clr_o,
   output logic [`ZS_ADDR_W-1:0]        dram_base_o,
   output logic                         core_resetn_o
);

   localparam int CNT_W = $clog2(`ZS_IO_DEPTH + 1);

   // the four host-writable registers
   logic [`ZS_DATA_W-1:0] run_r;
   logic [`ZS_DATA_W-1:0] alloc_r;
   logic [`ZS_DATA_W-1:0] base_r;
   logic [`ZS_DATA_W-1:0] core_r;

   logic                  access;
   logic                  mapped;
   logic                  read_only;
   logic                  bad;
   logic                  wr_en;
   logic [`ZS_DATA_W-1:0] rdata;

   // no wait states, every access phase completes at once
   assign access   = psel_i & penable_i;
   assign pready_o = access;

   // address decode and read mux
   always_comb
   begin
      rdata     = '0;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (paddr_i)
         `ZS_REG_RUN:   rdata = run_r;
         `ZS_REG_ALLOC: rdata = alloc_r;
         `ZS_REG_BASE:  rdata = base_r;
         `ZS_REG_CORE:  rdata = core_r;
         `ZS_REG_PROF, `ZS_REG_PROF + 8'h04, `ZS_REG_PROF + 8'h08, `ZS_REG_PROF + 8'h0C:
         begin
            // the profiler block starts on a 16-byte boundary, so bits 3:2 pick the word
            rdata     = prof_map_i[{paddr_i[3:2], 5'b00000} +: `ZS_DATA_W];
            read_only = 1'b1;
         end
         `ZS_REG_IO_POP:
         begin
            // an empty queue reads as zero and nothing is popped
            rdata     = fifo_empty_i ? '0 : fifo_word_i.raw;
            read_only = 1'b1;
         end
         `ZS_REG_IO_CNT:
         begin
            rdata     = {{(`ZS_DATA_W - CNT_W){1'b0}}, fifo_count_i};
            read_only = 1'b1;
         end
         default: mapped = 1'b0;
      endcase
   end

   // unmapped addresses and writes to read-only words are refused
   assign bad       = ~mapped | (pwrite_i & read_only);
   assign pslverr_o = access & bad;
   assign wr_en     = access & pwrite_i & ~bad;
   assign prdata_o  = rdata;

   // the head word leaves at the end of the access phase that returned it
   assign fifo_pop_o = access & ~pwrite_i & (paddr_i == `ZS_REG_IO_POP) & ~fifo_empty_i;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_r   <= '0;
         alloc_r <= '0;
         base_r  <= '0;
         core_r  <= '0;
      end
      else if (wr_en)
      begin
         case (paddr_i)
            `ZS_REG_RUN:   run_r   <= pwdata_i;
            `ZS_REG_ALLOC: alloc_r <= pwdata_i;
            `ZS_REG_BASE:  base_r  <= pwdata_i;
            `ZS_REG_CORE:  core_r  <= pwdata_i;
            default: ;
         endcase
      end
   end

   // the shell stays in clear until the host sets RUN bit 0
   assign shell_clr_o = ~run_r[0];
   assign dram_base_o = base_r;
   // the core only leaves reset when the shell reset is also released
   assign core_resetn_o = core_r[0] & arst_n_i;

   // an access phase is always part of a selected transfer
   a_penable_with_psel: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      penable_i |-> psel_i
   );

endmodule

`default_nettype wire

// ==== csr/io_fifo.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module io_fifo
#(
   parameter int DEPTH = `ZS_IO_DEPTH
)
(
   input  wire                          aclk_i,
   input  wire                          arst_n_i,
   input  wire                          clr_i,
   input  wire                          io_valid_i,
   output logic                         io_ready_o,
   input  wire [`ZS_IO_ADDR_W-1:0]      io_addr_i,
   input  wire [`ZS_IO_DATA_W-1:0]      io_data_i,
   input  wire                          pop_i,
   output zynq_shell_pkg::io_word_u     word_o,
   output logic                         empty_o,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   zynq_shell_pkg::io_word_u mem [DEPTH];
   zynq_shell_pkg::io_word_u wr_word;

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;

   // input is refused while full and while the shell is held in clear
   assign io_ready_o = ~clr_i & (count != CNT_W'(DEPTH));
   assign push       = io_valid_i & io_ready_o;

   // pack the write as valid, low address bits and the data byte
   always_comb
   begin
      wr_word.fld.valid = io_valid_i;
      wr_word.fld.addr  = io_addr_i;
      wr_word.fld.data  = io_data_i;
   end

   always_ff @(posedge aclk_i)
   begin
      if (push)
         mem[wr_ptr] <= wr_word;
   end

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clr_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap at DEPTH so any depth works, not only powers of two
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   assign word_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign count_o = count;

   // the register block only pops a word that it has just returned
   a_no_pop_empty: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      pop_i |-> !empty_o
   );

endmodule

`default_nettype wire

// ==== source/host_xlate.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module host_xlate
(
   input  wire                    aclk_i,
   input  wire                    arst_n_i,
   input  wire                    clr_i,
   input  wire                    host_valid_i,
   output logic                   host_ready_o,
   input  wire                    host_we_i,
   input  wire [`ZS_ADDR_W-1:0]   host_addr_i,
   output logic                   core_valid_o,
   input  wire                    core_ready_i,
   output logic                   core_we_o,
   output logic [`ZS_ADDR_W-1:0]  core_addr_o
);

   zynq_shell_pkg::host_addr_u haddr;

   logic                  take;
   logic                  valid_r;
   logic                  we_r;
   logic [`ZS_ADDR_W-1:0] addr_r;
   logic [`ZS_ADDR_W-1:0] xlated;

   assign haddr.raw = host_addr_i;

   // window 0 lands on core DRAM at 0x8000_0000, window 1 on core address zero
   assign xlated = {~haddr.fld.win, 3'b000, haddr.fld.offset};

   // the single entry may refill in the same cycle that it drains
   assign host_ready_o = ~clr_i & (~valid_r | core_ready_i);
   assign take         = host_valid_i & host_ready_o;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_r <= 1'b0;
      else if (clr_i)
         valid_r <= 1'b0;
      else if (take)
         valid_r <= 1'b1;
      else if (core_ready_i)
         valid_r <= 1'b0;
   end

   always_ff @(posedge aclk_i)
   begin
      if (take)
      begin
         we_r   <= host_we_i;
         addr_r <= xlated;
      end
   end

   assign core_valid_o = valid_r;
   assign core_we_o    = we_r;
   assign core_addr_o  = addr_r;

   // a stalled request keeps its payload until the core takes it
   a_stall_stable: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      (core_valid_o && !core_ready_i && !clr_i)
         |=> (core_valid_o && $stable(core_addr_o) && $stable(core_we_o))
   );

endmodule

`default_nettype wire

// ==== source/dram_xlate.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module dram_xlate
(
   input  wire                    aclk_i,
   input  wire                    arst_n_i,
   input  wire                    clr_i,
   mem_req_if.sink                req,
   input  wire [`ZS_ADDR_W-1:0]   base_i,
   output logic                   dram_valid_o,
   input  wire                    dram_ready_i,
   output logic                   dram_we_o,
   output logic [`ZS_ADDR_W-1:0]  dram_addr_o
);

   logic                  take;
   logic                  valid_r;
   logic                  we_r;
   logic [`ZS_ADDR_W-1:0] addr_r;
   logic [`ZS_ADDR_W-1:0] rebased;

   // xor strips the core DRAM base, then the host allocation is added
   // the sum wraps modulo 2^32
   assign rebased = (req.addr ^ `ZS_DRAM_FLIP) + base_i;

   // one entry, refilled in the cycle that it drains
   assign req.ready = ~clr_i & (~valid_r | dram_ready_i);
   assign take      = req.valid & req.ready;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_r <= 1'b0;
      else if (clr_i)
         valid_r <= 1'b0;
      else if (take)
         valid_r <= 1'b1;
      else if (dram_ready_i)
         valid_r <= 1'b0;
   end

   // the base is sampled when the request is taken, later base writes do not move it
   always_ff @(posedge aclk_i)
   begin
      if (take)
      begin
         we_r   <= req.we;
         addr_r <= rebased;
      end
   end

   assign dram_valid_o = valid_r;
   assign dram_we_o    = we_r;
   assign dram_addr_o  = addr_r;

   // under back-pressure the DRAM port sees the same request every cycle
   a_stall_stable: assert property (
      @(posedge aclk_i) disable iff (!arst_n_i)
      (dram_valid_o && !dram_ready_i && !clr_i)
         |=> (dram_valid_o && $stable(dram_addr_o) && $stable(dram_we_o))
   );

endmodule

`default_nettype wire

// ==== source/mem_profiler.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module mem_profiler
(
   input  wire                         aclk_i,
   input  wire                         arst_n_i,
   input  wire                         clr_i,
   mem_req_if.monitor                  req,
   output logic [`ZS_PROF_BITS-1:0]    map_o
);

   logic [`ZS_PROF_BITS-1:0]  map_r;
   logic [`ZS_PROF_IDX_W-1:0] region;
   logic                      hit;

   // each bit stands for one 8 MB region of core address space
   assign region = req.addr[`ZS_PROF_LSB +: `ZS_PROF_IDX_W];
   // only requests that the DRAM side actually takes are counted
   assign hit    = req.valid & req.ready;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         map_r <= '0;
      else if (clr_i)
         map_r <= '0;
      else if (hit)
         map_r[region] <= 1'b1;
   end

   // bits are sticky, the host sees every region touched since the last clear
   assign map_o = map_r;

endmodule

`default_nettype wire

// ==== source/zynq_shell_top.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module zynq_shell_top
(
   input  wire                          aclk_i,
   input  wire                          arst_n_i,
   input  wire [`ZS_APB_ADDR_W-1:0]     paddr_i,
   input  wire                          psel_i,
   input  wire                          penable_i,
   input  wire                          pwrite_i,
   input  wire [`ZS_DATA_W-1:0]         pwdata_i,
   output logic [`ZS_DATA_W-1:0]        prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   input  wire                          host_valid_i,
   output logic                         host_ready_o,
   input  wire                          host_we_i,
   input  wire [`ZS_ADDR_W-1:0]         host_addr_i,
   output logic                         core_valid_o,
   input  wire                          core_ready_i,
   output logic                         core_we_o,
   output logic [`ZS_ADDR_W-1:0]        core_addr_o,
   input  wire                          dram_req_valid_i,
   output logic                         dram_req_ready_o,
   input  wire                          dram_req_we_i,
   input  wire [`ZS_ADDR_W-1:0]         dram_req_addr_i,
   output logic                         dram_valid_o,
   input  wire                          dram_ready_i,
   output logic                         dram_we_o,
   output logic [`ZS_ADDR_W-1:0]        dram_addr_o,
   input  wire                          io_valid_i,
   output logic                         io_ready_o,
   input  wire [`ZS_IO_ADDR_W-1:0]      io_addr_i,
   input  wire [`ZS_IO_DATA_W-1:0]      io_data_i,
   output logic                         core_resetn_o
);

   logic                                  shell_clr;
   logic [`ZS_ADDR_W-1:0]                 dram_base;
   logic [`ZS_PROF_BITS-1:0]              prof_map;
   zynq_shell_pkg::io_word_u              fifo_word;
   logic                                  fifo_empty;
   logic [$clog2(`ZS_IO_DEPTH+1)-1:0]     fifo_count;
   logic                                  fifo_pop;

   // the core DRAM request is shared by the translator and the profiler
   mem_req_if dram_req ();

   assign dram_req.valid   = dram_req_valid_i;
   assign dram_req.we      = dram_req_we_i;
   assign dram_req.addr    = dram_req_addr_i;
   assign dram_req_ready_o = dram_req.ready;

   csr_apb u_csr (
      .aclk_i        (aclk_i),
      .arst_n_i      (arst_n_i),
      .paddr_i       (paddr_i),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .pwdata_i      (pwdata_i),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .prof_map_i    (prof_map),
      .fifo_word_i   (fifo_word),
      .fifo_empty_i  (fifo_empty),
      .fifo_count_i  (fifo_count),
      .fifo_pop_o    (fifo_pop),
      .shell_clr_o   (shell_clr),
      .dram_base_o   (dram_base),
      .core_resetn_o (core_resetn_o)
   );

   io_fifo #(.DEPTH(`ZS_IO_DEPTH)) u_io_fifo (
      .aclk_i     (aclk_i),
      .arst_n_i   (arst_n_i),
      .clr_i      (shell_clr),
      .io_valid_i (io_valid_i),
      .io_ready_o (io_ready_o),
      .io_addr_i  (io_addr_i),
      .io_data_i  (io_data_i),
      .pop_i      (fifo_pop),
      .word_o     (fifo_word),
      .empty_o    (fifo_empty),
      .count_o    (fifo_count)
   );

   host_xlate u_host_xlate (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .clr_i        (shell_clr),
      .host_valid_i (host_valid_i),
      .host_ready_o (host_ready_o),
      .host_we_i    (host_we_i),
      .host_addr_i  (host_addr_i),
      .core_valid_o (core_valid_o),
      .core_ready_i (core_ready_i),
      .core_we_o    (core_we_o),
      .core_addr_o  (core_addr_o)
   );

   dram_xlate u_dram_xlate (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .clr_i        (shell_clr),
      .req          (dram_req.sink),
      .base_i       (dram_base),
      .dram_valid_o (dram_valid_o),
      .dram_ready_i (dram_ready_i),
      .dram_we_o    (dram_we_o),
      .dram_addr_o  (dram_addr_o)
   );

   mem_profiler u_mem_profiler (
      .aclk_i   (aclk_i),
      .arst_n_i (arst_n_i),
      .clr_i    (shell_clr),
      .req      (dram_req.monitor),
      .map_o    (prof_map)
   );

endmodule

`default_nettype wire

// ==== tests/clk_gen.sv ====
`default_nettype none

module clk_gen
#(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 10
)
(
   output logic clk_o,
   output logic arst_n_o
);

   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset is released just after a rising edge so no flop sees it change at the edge
   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/tb_zynq_shell.sv ====
`default_nettype none

`include "zynq_shell_consts.svh"

module tb_zynq_shell;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 200;
   localparam int RUN_LIMIT  = 20000;
   localparam int N_REQ      = 40;
   localparam logic [7:0] UNMAPPED [5] = '{8'h28, 8'h30, 8'h80, 8'hFC, 8'h06};
   localparam logic [7:0] READ_ONLY [6] = '{8'h10, 8'h14, 8'h18, 8'h1C, 8'h20, 8'h24};

   logic        clk;
   logic        arst_n;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        host_valid;
   logic        host_ready;
   logic        host_we;
   logic [31:0] host_addr;
   logic        core_valid;
   logic        core_ready;
   logic        core_we;
   logic [31:0] core_addr;
   logic        dram_req_valid;
   logic        dram_req_ready;
   logic        dram_req_we;
   logic [31:0] dram_req_addr;
   logic        dram_valid;
   logic        dram_ready;
   logic        dram_we;
   logic [31:0] dram_addr;
   logic        io_valid;
   logic        io_ready;
   logic [22:0] io_addr;
   logic [7:0]  io_data;
   logic        core_resetn;

   // expected stream outputs in the order they were accepted
   logic [31:0]  exp_addr_q [$];
   logic         exp_we_q [$];
   // expected i/o words in push order
   logic [31:0]  io_q [$];
   // RUN, ALLOC, BASE and CORE indexed by address bits 3:2
   logic [31:0]  reg_model [4];
   logic [127:0] prof_model;

   int n_checks   = 0;
   int n_errors   = 0;
   int n_timeouts = 0;

   clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) u_clk_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   zynq_shell_top UUT (
      .aclk_i           (clk),
      .arst_n_i         (arst_n),
      .paddr_i          (paddr),
      .psel_i           (psel),
      .penable_i        (penable),
      .pwrite_i         (pwrite),
      .pwdata_i         (pwdata),
      .prdata_o         (prdata),
      .pready_o         (pready),
      .pslverr_o        (pslverr),
      .host_valid_i     (host_valid),
      .host_ready_o     (host_ready),
      .host_we_i        (host_we),
      .host_addr_i      (host_addr),
      .core_valid_o     (core_valid),
      .core_ready_i     (core_ready),
      .core_we_o        (core_we),
      .core_addr_o      (core_addr),
      .dram_req_valid_i (dram_req_valid),
      .dram_req_ready_o (dram_req_ready),
      .dram_req_we_i    (dram_req_we),
      .dram_req_addr_i  (dram_req_addr),
      .dram_valid_o     (dram_valid),
      .dram_ready_i     (dram_ready),
      .dram_we_o        (dram_we),
      .dram_addr_o      (dram_addr),
      .io_valid_i       (io_valid),
      .io_ready_o       (io_ready),
      .io_addr_i        (io_addr),
      .io_data_i        (io_data),
      .core_resetn_o    (core_resetn)
   );

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic timed_out(input string what);
      n_timeouts++;
      $display("Timed out at %0t ns while waiting for %s", $time, what);
   endtask

   // all stimulus changes 2 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   // window 0 lands at 0x8000_0000 plus the offset and window 1 at the offset alone
   function automatic logic [31:0] host_model(input logic [31:0] a);
      logic [31:0] off;
      off = {4'h0, a[27:0]};
      return a[29] ? off : 32'h8000_0000 + off;
   endfunction

   // the offset from the core DRAM base is moved onto the allocated host base
   function automatic logic [31:0] dram_model(input logic [31:0] a);
      return a - 32'h8000_0000 + reg_model[2];
   endfunction

   // one APB transfer with a setup and an access phase
   task automatic apb_access(input logic [7:0] addr, input bit wr, input logic [31:0] wdata,
                             input bit exp_err, output logic [31:0] rdata);
      int waited;
      bit rdy;
      step();
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      step();
      penable = 1'b1;
      waited  = 0;
      rdy     = 1'b0;
      while (!rdy && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         rdy = pready;
         if (!rdy)
         begin
            step();
            waited++;
         end
      end
      if (!rdy)
         timed_out("APB pready");
      rdata = prdata;
      compare($sformatf("pslverr at 0x%h", addr), pslverr, exp_err);
      step();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input bit exp_err);
      logic [31:0] unused;
      apb_access(addr, 1'b1, data, exp_err, unused);
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input bit exp_err);
      logic [31:0] rd;
      apb_access(addr, 1'b0, '0, exp_err, rd);
      compare($sformatf("read of 0x%h", addr), rd, exp);
   endtask

   // everything readable except IO_POP, which would pop
   task automatic check_all_regs();
      for (int i = 0; i < 4; i++)
         read_expect(8'(i * 4), reg_model[i], 1'b0);
      for (int i = 0; i < 4; i++)
         read_expect(`ZS_REG_PROF + 8'(i * 4), prof_model[i * 32 +: 32], 1'b0);
      read_expect(`ZS_REG_IO_CNT, 32'(io_q.size()), 1'b0);
   endtask

   task automatic send_reqs(input bit to_dram, input int n);
      logic [31:0] a;
      logic        w;
      bit          acc;
      int          waited;
      for (int i = 0; i < n; i++)
      begin
         a = $urandom;
         w = 1'($urandom_range(1));
         if (to_dram)
         begin
            dram_req_valid = 1'b1;
            dram_req_we    = w;
            dram_req_addr  = a;
         end
         else
         begin
            host_valid = 1'b1;
            host_we    = w;
            host_addr  = a;
         end
         acc    = 1'b0;
         waited = 0;
         while (!acc && waited < WAIT_LIMIT)
         begin
            @(negedge clk);
            acc = to_dram ? dram_req_ready : host_ready;
            // the request is taken at the coming edge
            if (acc)
            begin
               exp_addr_q.push_back(to_dram ? dram_model(a) : host_model(a));
               exp_we_q.push_back(w);
               if (to_dram)
                  prof_model[a[29:23]] = 1'b1;
            end
            step();
            waited++;
         end
         if (!acc)
            timed_out(to_dram ? "DRAM request ready" : "host request ready");
         host_valid     = 1'b0;
         dram_req_valid = 1'b0;
         // an occasional idle cycle between requests
         if ($urandom_range(3) == 0)
            step();
      end
   endtask

   // drives random ready on the output side and matches each taken request to the model
   task automatic take_reqs(input bit from_dram, input int n);
      int          got;
      int          idle;
      bit          rdy;
      bit          vld;
      logic [31:0] a;
      logic        w;
      got  = 0;
      idle = 0;
      while (got < n && idle < WAIT_LIMIT)
      begin
         step();
         rdy = ($urandom_range(3) != 0);
         if (from_dram)
            dram_ready = rdy;
         else
            core_ready = rdy;
         @(negedge clk);
         vld = from_dram ? dram_valid : core_valid;
         a   = from_dram ? dram_addr : core_addr;
         w   = from_dram ? dram_we : core_we;
         if (vld && rdy)
         begin
            if (exp_addr_q.size() == 0)
            begin
               n_errors++;
               $display("An output request at %0t ns had no matching input request", $time);
            end
            else
            begin
               compare("translated address", a, exp_addr_q.pop_front());
               compare("write flag", w, exp_we_q.pop_front());
            end
            got++;
            idle = 0;
         end
         else
            idle++;
      end
      if (got < n)
         timed_out(from_dram ? "DRAM output requests" : "core output requests");
   endtask

   task automatic push_io(input int n);
      logic [31:0] r;
      bit          acc;
      int          waited;
      for (int i = 0; i < n; i++)
      begin
         r        = $urandom;
         io_addr  = r[22:0];
         io_data  = 8'($urandom);
         io_valid = 1'b1;
         acc      = 1'b0;
         waited   = 0;
         while (!acc && waited < WAIT_LIMIT)
         begin
            @(negedge clk);
            acc = io_ready;
            // the valid flag sits on top of the address and the data byte
            if (acc)
               io_q.push_back({1'b1, io_addr, io_data});
            step();
            waited++;
         end
         if (!acc)
            timed_out("io_ready_o");
         io_valid = 1'b0;
      end
   endtask

   // pops every expected word and then checks that an empty pop reads as zero
   task automatic drain_io();
      read_expect(`ZS_REG_IO_CNT, 32'(io_q.size()), 1'b0);
      while (io_q.size() > 0)
         read_expect(`ZS_REG_IO_POP, io_q.pop_front(), 1'b0);
      read_expect(`ZS_REG_IO_CNT, 32'h0, 1'b0);
      read_expect(`ZS_REG_IO_POP, 32'h0, 1'b0);
   endtask

   initial
   begin
      for (int c = 0; c < RUN_LIMIT; c++)
         @(posedge clk);
      $display("Timed out. The run did not finish within %0d cycles", RUN_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      int          waited;
      logic [31:0] data;
      logic [31:0] r;
      void'($urandom(98750));
      paddr          = '0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      pwdata         = '0;
      host_valid     = 1'b0;
      host_we        = 1'b0;
      host_addr      = '0;
      core_ready     = 1'b0;
      dram_req_valid = 1'b0;
      dram_req_we    = 1'b0;
      dram_req_addr  = '0;
      dram_ready     = 1'b0;
      io_valid       = 1'b0;
      io_addr        = '0;
      io_data        = '0;
      for (int i = 0; i < 4; i++)
         reg_model[i] = '0;
      prof_model = '0;

      waited = 0;
      while (arst_n !== 1'b1 && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (arst_n !== 1'b1)
         timed_out("reset release");
      step();

      // after reset nothing is valid and every register reads zero
      compare("core_valid_o after reset", core_valid, 1'b0);
      compare("dram_valid_o after reset", dram_valid, 1'b0);
      compare("core_resetn_o after reset", core_resetn, 1'b0);
      compare("pready_o after reset", pready, 1'b0);
      compare("pslverr_o after reset", pslverr, 1'b0);
      check_all_regs();
      read_expect(`ZS_REG_IO_POP, 32'h0, 1'b0);

      // random register writes with readback
      for (int i = 0; i < 4; i++)
      begin
         for (int k = 0; k < 3; k++)
         begin
            data = $urandom;
            apb_write(8'(i * 4), data, 1'b0);
            reg_model[i] = data;
            read_expect(8'(i * 4), reg_model[i], 1'b0);
         end
      end
      // unmapped words refuse both directions and read as zero
      foreach (UNMAPPED[i])
      begin
         apb_write(UNMAPPED[i], $urandom, 1'b1);
         read_expect(UNMAPPED[i], 32'h0, 1'b1);
      end
      foreach (READ_ONLY[i])
         apb_write(READ_ONLY[i], $urandom, 1'b1);
      check_all_regs();
      // the core reset follows CORE bit 0
      apb_write(`ZS_REG_CORE, 32'h1, 1'b0);
      reg_model[3] = 32'h1;
      compare("core_resetn_o with CORE set", core_resetn, 1'b1);
      apb_write(`ZS_REG_CORE, 32'h0, 1'b0);
      reg_model[3] = 32'h0;
      compare("core_resetn_o with CORE clear", core_resetn, 1'b0);

      // the shell clear is released before the host window traffic
      apb_write(`ZS_REG_RUN, 32'h1, 1'b0);
      reg_model[0] = 32'h1;
      // every empty input stage takes a request even with its output stalled
      compare("host_ready_o when empty", host_ready, 1'b1);
      compare("dram_req_ready_o when empty", dram_req_ready, 1'b1);
      compare("io_ready_o when empty", io_ready, 1'b1);
      exp_addr_q.delete();
      exp_we_q.delete();
      fork
         send_reqs(1'b0, N_REQ);
         take_reqs(1'b0, N_REQ);
      join

      // DRAM traffic against a random allocated base
      r = $urandom;
      apb_write(`ZS_REG_BASE, r, 1'b0);
      reg_model[2] = r;
      fork
         send_reqs(1'b1, N_REQ);
         take_reqs(1'b1, N_REQ);
      join
      for (int i = 0; i < 4; i++)
         read_expect(`ZS_REG_PROF + 8'(i * 4), prof_model[i * 32 +: 32], 1'b0);

      // a partly filled queue is drained before a full one has to refuse more
      push_io(int'($urandom_range(7, 1)));
      drain_io();
      push_io(`ZS_IO_DEPTH);
      io_valid = 1'b1;
      io_addr  = 23'h1;
      io_data  = 8'hA5;
      for (int k = 0; k < 3; k++)
      begin
         @(negedge clk);
         compare("io_ready_o while full", io_ready, 1'b0);
         step();
      end
      io_valid = 1'b0;
      drain_io();

      // a RUN toggle wipes the profiler map and the queue
      push_io(3);
      apb_write(`ZS_REG_RUN, 32'h0, 1'b0);
      apb_write(`ZS_REG_RUN, 32'h1, 1'b0);
      prof_model = '0;
      io_q.delete();
      check_all_regs();
      read_expect(`ZS_REG_IO_POP, 32'h0, 1'b0);

      $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
               n_checks, n_errors, n_timeouts);
      if (n_errors == 0 && n_timeouts == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/zynq_shell_pkg.sv
common/mem_req_if.sv
csr/csr_apb.sv
csr/io_fifo.sv
source/host_xlate.sv
source/dram_xlate.sv
source/mem_profiler.sv
source/zynq_shell_top.sv
tests/clk_gen.sv
tests/tb_zynq_shell.sv

// ==== Makefile ====
# Verilator build and run of the zynq shell testbench
TOP := tb_zynq_shell
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
